// ==== source/mcoi_link_defines.svh ====
/* link subsystem build constants */
`ifndef MCOI_LINK_DEFINES_SVH
`define MCOI_LINK_DEFINES_SVH

// ----------------------------------------
// reset and heartbeat timing
// ----------------------------------------
// internal reset cycles after external release
`define POR_CYCLES 16
// blinker half periods in clk cycles
`define HB_FAST_HALF 8
`define HB_SLOW_HALF 12

// ----------------------------------------
// register reset values
// ----------------------------------------
`define FRAME_DIV_RST 3
`define STRETCH_RST 4
// pattern enabled, los honoured
`define CTRL_RST 1
// ascii "MCOI"
`define LINK_ID 32'h4d43_4f49

// ----------------------------------------
// register map
// ----------------------------------------
`define ADDR_CTRL 4'h0
`define ADDR_FRAME_DIV 4'h1
`define ADDR_STRETCH 4'h2
// read only from here on
`define ADDR_TX_COUNT 4'h3
`define ADDR_RX_FRAMES 4'h4
`define ADDR_ID 4'h5

`endif

// ==== source/mcoi_link_pkg.sv ====
/* link subsystem types */
`default_nettype none

package mcoi_link_pkg;

  // ----------------------------------------
  // data widths
  // ----------------------------------------
  // register and counter word
  typedef logic [31:0] word_t;

  // one link frame, two words side by side
  typedef logic [63:0] frame_t;

  // register address on the cpu side
  typedef logic [3:0] reg_addr_t;

  // ----------------------------------------
  // reset sequencer
  // ----------------------------------------
  // hold while external reset is low
  // count out the stretch
  // run with internal reset released
  typedef enum logic [1:0] {
    HOLD  = 2'd0,
    COUNT = 2'd1,
    RUN   = 2'd2
  } por_state_e;

endpackage

`default_nettype wire

// ==== source/link_cfg_if.sv ====
/* link config and status bundle */
`default_nettype none

interface link_cfg_if;
  import mcoi_link_pkg::*;

  // ----------------------------------------
  // registers to datapath
  // ----------------------------------------
  // ctrl bit 0
  logic  pattern_en;
  // ctrl bit 1, count runs through los
  logic  los_override;
  // strobe period, never 0
  word_t frame_div;
  // led hold after a received frame
  word_t stretch_len;

  // ----------------------------------------
  // datapath status back to registers
  // ----------------------------------------
  word_t tx_count;
  word_t rx_frames;

  // register block drives the config
  modport regs (
    output pattern_en, los_override, frame_div, stretch_len,
    input  tx_count, rx_frames
  );

  // pattern generator side
  modport gen (
    input  pattern_en, los_override, frame_div,
    output tx_count
  );

  // receive monitor side
  modport mon (
    input  stretch_len,
    output rx_frames
  );

endinterface

`default_nettype wire

// ==== source/por_reset_gen.sv ====
/* power-on reset stretcher */
`default_nettype none
`include "mcoi_link_defines.svh"

module por_reset_gen (
  input  logic clk_tree_x,
  input  logic rst_n_i,
  output logic sys_rst_n_o
);
  import mcoi_link_pkg::*;

  localparam int unsigned POR_CYCLES = `POR_CYCLES;
  // one spare bit so the terminal value always fits
  localparam int unsigned CNT_W = $clog2(POR_CYCLES + 1);

  por_state_e       state_q;
  logic [CNT_W-1:0] cnt_q;

  // ----------------------------------------
  // sequencer
  // ----------------------------------------
  always_ff @(posedge clk_tree_x) begin
    if (!rst_n_i) begin
      // external reset low, back to hold
      state_q <= HOLD;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        HOLD: begin
          // first edge with rst_n_i high
          state_q <= COUNT;
          cnt_q   <= '0;
        end
        COUNT: begin
          cnt_q <= cnt_q + CNT_W'(1);
          // last stretch cycle
          if (cnt_q == CNT_W'(POR_CYCLES - 1)) begin
            state_q <= RUN;
          end
        end
        RUN: begin
          state_q <= RUN;
        end
        default: begin
          state_q <= HOLD;
        end
      endcase
    end
  end

  // decode of the state register only
  assign sys_rst_n_o = (state_q == RUN);

endmodule

`default_nettype wire

// ==== source/heartbeat_blinker.sv ====
/* heartbeat led divider */
`default_nettype none

module heartbeat_blinker #(
  // cycles per led level, 2 or more
  parameter int unsigned HALF_PERIOD = 2
) (
  input  logic clk_tree_x,
  input  logic rst_n_i,
  output logic led_o
);

  localparam int unsigned CNT_W = $clog2(HALF_PERIOD);

  logic [CNT_W-1:0] cnt_q;
  logic             wrap;

  // ----------------------------------------
  // free-running divider
  // ----------------------------------------
  // end of one half period
  assign wrap = (cnt_q == CNT_W'(HALF_PERIOD - 1));

  always_ff @(posedge clk_tree_x) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      led_o <= 1'b0;
    end else begin
      if (wrap) begin
        cnt_q <= '0;
        // flip level at the wrap
        led_o <= ~led_o;
      end else begin
        cnt_q <= cnt_q + CNT_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/frame_pattern_gen.sv ====
/* frame strobe and test pattern */
`default_nettype none
`include "mcoi_link_defines.svh"

module frame_pattern_gen (
  input  logic                  clk_tree_x,
  input  logic                  rst_n_i,
  input  logic                  los_i,
  link_cfg_if.gen               cfg_if,
  output logic                  tx_frame_o,
  output mcoi_link_pkg::frame_t tx_data_o
);
  import mcoi_link_pkg::*;

  // period the timer is running on
  word_t div_q;
  word_t timer_q;
  word_t count_q;
  word_t count_nxt;
  logic  div_changed;
  logic  strobe;

  // ----------------------------------------
  // strobe timer
  // ----------------------------------------
  // new period written, restart
  assign div_changed = (cfg_if.frame_div != div_q);
  // last cycle of the period
  assign strobe = !div_changed && (timer_q == cfg_if.frame_div - word_t'(1));

  always_ff @(posedge clk_tree_x) begin
    if (!rst_n_i) begin
      // matches the register reset value, no restart after reset
      div_q   <= word_t'(`FRAME_DIV_RST);
      timer_q <= '0;
    end else if (div_changed) begin
      div_q   <= cfg_if.frame_div;
      timer_q <= '0;
    end else if (strobe) begin
      timer_q <= '0;
    end else begin
      timer_q <= timer_q + word_t'(1);
    end
  end

  // ----------------------------------------
  // counting pattern
  // ----------------------------------------
  always_comb begin
    if (los_i && !cfg_if.los_override) begin
      // link down, start over
      count_nxt = '0;
    end else if (cfg_if.pattern_en) begin
      count_nxt = count_q + word_t'(1);
    end else begin
      count_nxt = count_q;
    end
  end

  always_ff @(posedge clk_tree_x) begin
    if (!rst_n_i) begin
      count_q    <= '0;
      tx_frame_o <= 1'b0;
    end else begin
      tx_frame_o <= strobe;
      // count moves on strobes only
      if (strobe) begin
        count_q <= count_nxt;
      end
    end
  end

  // same word in both halves, changes with the pulse
  assign tx_data_o       = {count_q, count_q};
  assign cfg_if.tx_count = count_q;

endmodule

`default_nettype wire

// ==== source/rx_activity_monitor.sv ====
/* receive activity monitor */
`default_nettype none

module rx_activity_monitor (
  input  logic                  clk_tree_x,
  input  logic                  rst_n_i,
  input  logic                  rx_valid_i,
  input  mcoi_link_pkg::frame_t rx_data_i,
  link_cfg_if.mon               cfg_if,
  output logic                  act_led_o
);
  import mcoi_link_pkg::*;

  logic  frame_hit;
  word_t hold_q;
  word_t rx_frames_q;

  // ----------------------------------------
  // frame detect
  // ----------------------------------------
  // idle link sends zero words
  assign frame_hit = rx_valid_i && (|rx_data_i);

  // ----------------------------------------
  // led stretch
  // ----------------------------------------
  always_ff @(posedge clk_tree_x) begin
    if (!rst_n_i) begin
      hold_q <= '0;
    end else if (frame_hit) begin
      // zero length keeps the led dark
      hold_q <= cfg_if.stretch_len;
    end else if (hold_q != '0) begin
      hold_q <= hold_q - word_t'(1);
    end
  end

  assign act_led_o = (hold_q != '0);

  // ----------------------------------------
  // frame counter
  // ----------------------------------------
  always_ff @(posedge clk_tree_x) begin
    if (!rst_n_i) begin
      rx_frames_q <= '0;
    end else if (frame_hit && (rx_frames_q != '1)) begin
      // stick at all ones
      rx_frames_q <= rx_frames_q + word_t'(1);
    end
  end

  assign cfg_if.rx_frames = rx_frames_q;

endmodule

`default_nettype wire

// ==== source/link_ctrl_regs.sv ====
/* link control registers */
`default_nettype none
`include "mcoi_link_defines.svh"

module link_ctrl_regs (
  input  logic                     clk_tree_x,
  input  logic                     rst_n_i,
  input  logic                     wr_en_i,
  input  logic                     rd_en_i,
  input  mcoi_link_pkg::reg_addr_t addr_i,
  input  mcoi_link_pkg::word_t     wdata_i,
  output mcoi_link_pkg::word_t     rdata_o,
  output logic                     rvalid_o,
  link_cfg_if.regs                 cfg_if
);
  import mcoi_link_pkg::*;

  // bit 1 los override, bit 0 pattern enable
  logic [1:0] ctrl_q;
  word_t      frame_div_q;
  word_t      stretch_q;
  word_t      rd_mux;

  // ----------------------------------------
  // writable registers
  // ----------------------------------------
  always_ff @(posedge clk_tree_x) begin
    if (!rst_n_i) begin
      ctrl_q      <= 2'(`CTRL_RST);
      frame_div_q <= word_t'(`FRAME_DIV_RST);
      stretch_q   <= word_t'(`STRETCH_RST);
    end else if (wr_en_i) begin
      case (addr_i)
        `ADDR_CTRL: begin
          ctrl_q <= wdata_i[1:0];
        end
        `ADDR_FRAME_DIV: begin
          // zero period would stall the timer
          if (wdata_i == '0) begin
            frame_div_q <= word_t'(1);
          end else begin
            frame_div_q <= wdata_i;
          end
        end
        `ADDR_STRETCH: begin
          stretch_q <= wdata_i;
        end
        // read only and unmapped
        default: ;
      endcase
    end
  end

  // ----------------------------------------
  // readback
  // ----------------------------------------
  always_comb begin
    case (addr_i)
      `ADDR_CTRL:      rd_mux = word_t'(ctrl_q);
      `ADDR_FRAME_DIV: rd_mux = frame_div_q;
      `ADDR_STRETCH:   rd_mux = stretch_q;
      `ADDR_TX_COUNT:  rd_mux = cfg_if.tx_count;
      `ADDR_RX_FRAMES: rd_mux = cfg_if.rx_frames;
      `ADDR_ID:        rd_mux = `LINK_ID;
      default:         rd_mux = '0;
    endcase
  end

  // valid one cycle after the strobe
  always_ff @(posedge clk_tree_x) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= rd_en_i;
    end
  end

  // data only, qualified by rvalid_o
  // a write in the same cycle is not seen yet
  always_ff @(posedge clk_tree_x) begin
    if (rd_en_i) begin
      rdata_o <= rd_mux;
    end
  end

  // ----------------------------------------
  // config out
  // ----------------------------------------
  assign cfg_if.pattern_en   = ctrl_q[0];
  assign cfg_if.los_override = ctrl_q[1];
  assign cfg_if.frame_div    = frame_div_q;
  assign cfg_if.stretch_len  = stretch_q;

endmodule

`default_nettype wire

// ==== source/mcoi_link_top.sv ====
/* mcoi optical link subsystem */
`default_nettype none
`include "mcoi_link_defines.svh"

module mcoi_link_top (
  input  logic                     clk_tree_x,
  input  logic                     rst_n_i,
  // register port
  input  logic                     wr_en_i,
  input  logic                     rd_en_i,
  input  mcoi_link_pkg::reg_addr_t addr_i,
  input  mcoi_link_pkg::word_t     wdata_i,
  output mcoi_link_pkg::word_t     rdata_o,
  output logic                     rvalid_o,
  // link transmit
  output logic                     tx_frame_o,
  output mcoi_link_pkg::frame_t    tx_data_o,
  // link receive
  input  logic                     rx_valid_i,
  input  mcoi_link_pkg::frame_t    rx_data_i,
  input  logic                     los_i,
  // board leds and scope pins
  output logic [2:0]               led_o,
  output logic [3:0]               diag_o
);

  // stretched internal reset
  logic sys_rst_n;
  logic hb_fast;
  logic hb_slow;
  logic act_led;

  link_cfg_if cfg_if ();

  // ----------------------------------------
  // reset
  // ----------------------------------------
  por_reset_gen u_por_reset_gen (
    .clk_tree_x  (clk_tree_x),
    .rst_n_i     (rst_n_i),
    .sys_rst_n_o (sys_rst_n)
  );

  // ----------------------------------------
  // registers
  // ----------------------------------------
  link_ctrl_regs u_link_ctrl_regs (
    .clk_tree_x (clk_tree_x),
    .rst_n_i    (sys_rst_n),
    .wr_en_i    (wr_en_i),
    .rd_en_i    (rd_en_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .rdata_o    (rdata_o),
    .rvalid_o   (rvalid_o),
    .cfg_if     (cfg_if.regs)
  );

  // ----------------------------------------
  // link datapath
  // ----------------------------------------
  frame_pattern_gen u_frame_pattern_gen (
    .clk_tree_x (clk_tree_x),
    .rst_n_i    (sys_rst_n),
    .los_i      (los_i),
    .cfg_if     (cfg_if.gen),
    .tx_frame_o (tx_frame_o),
    .tx_data_o  (tx_data_o)
  );

  rx_activity_monitor u_rx_activity_monitor (
    .clk_tree_x (clk_tree_x),
    .rst_n_i    (sys_rst_n),
    .rx_valid_i (rx_valid_i),
    .rx_data_i  (rx_data_i),
    .cfg_if     (cfg_if.mon),
    .act_led_o  (act_led)
  );

  // ----------------------------------------
  // heartbeats
  // ----------------------------------------
  heartbeat_blinker #(
    .HALF_PERIOD (`HB_FAST_HALF)
  ) u_hb_fast (
    .clk_tree_x (clk_tree_x),
    .rst_n_i    (sys_rst_n),
    .led_o      (hb_fast)
  );

  heartbeat_blinker #(
    .HALF_PERIOD (`HB_SLOW_HALF)
  ) u_hb_slow (
    .clk_tree_x (clk_tree_x),
    .rst_n_i    (sys_rst_n),
    .led_o      (hb_slow)
  );

  // led 2 is receive activity
  assign led_o  = {act_led, hb_slow, hb_fast};
  // scope pins, frame strobe next to activity
  assign diag_o = {act_led, tx_frame_o, hb_slow, hb_fast};

endmodule

`default_nettype wire

// ==== dv/tb_mcoi_link_top.sv ====
/* link subsystem testbench */
`default_nettype none
`include "mcoi_link_defines.svh"

module tb_mcoi_link_top;
  timeunit 1ns;
  timeprecision 100ps;
  import mcoi_link_pkg::*;

  // about twice the planned run length
  localparam int TIMEOUT_CYCLES = 4000;

  logic      clk_tree_x = 1'b0;
  logic      rst_n_i;
  logic      wr_en_i;
  logic      rd_en_i;
  reg_addr_t addr_i;
  word_t     wdata_i;
  word_t     rdata_o;
  logic      rvalid_o;
  logic      tx_frame_o;
  frame_t    tx_data_o;
  logic      rx_valid_i;
  frame_t    rx_data_i;
  logic      los_i;
  logic [2:0] led_o;
  logic [3:0] diag_o;

  integer seed;
  int     cycle_count = 0;
  bit     checks_on = 1'b0;

  // model state as seen after the last rising edge
  int         m_por_cnt;
  bit         m_sys;
  logic [1:0] m_ctrl;
  word_t      m_fdiv;
  word_t      m_stretch;
  word_t      m_rdata;
  logic       m_rvalid;
  word_t      m_tmr_div;
  word_t      m_tmr_phase;
  word_t      m_count;
  logic       m_txf;
  word_t      m_hold;
  word_t      m_rxf;
  int         m_fast_cnt;
  int         m_slow_cnt;
  logic       m_fast;
  logic       m_slow;

  mcoi_link_top i_mcoi_link_top (
    .clk_tree_x (clk_tree_x),
    .rst_n_i    (rst_n_i),
    .wr_en_i    (wr_en_i),
    .rd_en_i    (rd_en_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .rdata_o    (rdata_o),
    .rvalid_o   (rvalid_o),
    .tx_frame_o (tx_frame_o),
    .tx_data_o  (tx_data_o),
    .rx_valid_i (rx_valid_i),
    .rx_data_i  (rx_data_i),
    .los_i      (los_i),
    .led_o      (led_o),
    .diag_o     (diag_o)
  );

  // 10 ns clock
  always #5 clk_tree_x = ~clk_tree_x;

  // ----------------------------------------
  // watchdog
  // ----------------------------------------
  always @(posedge clk_tree_x) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles without finishing", cycle_count);
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
    end
  end

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, expected);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // ----------------------------------------
  // cycle model
  // ----------------------------------------
  // register map as the cpu sees it
  function automatic word_t model_readback(input reg_addr_t addr);
    word_t value;
    case (addr)
      `ADDR_CTRL:      value = word_t'(m_ctrl);
      `ADDR_FRAME_DIV: value = m_fdiv;
      `ADDR_STRETCH:   value = m_stretch;
      `ADDR_TX_COUNT:  value = m_count;
      `ADDR_RX_FRAMES: value = m_rxf;
      `ADDR_ID:        value = `LINK_ID;
      default:         value = '0;
    endcase
    return value;
  endfunction

  task automatic load_reset_values();
    m_ctrl      = 2'(`CTRL_RST);
    m_fdiv      = word_t'(`FRAME_DIV_RST);
    m_stretch   = word_t'(`STRETCH_RST);
    m_rvalid    = 1'b0;
    m_tmr_div   = word_t'(`FRAME_DIV_RST);
    m_tmr_phase = '0;
    m_count     = '0;
    m_txf       = 1'b0;
    m_hold      = '0;
    m_rxf       = '0;
    m_fast_cnt  = 0;
    m_slow_cnt  = 0;
    m_fast      = 1'b0;
    m_slow      = 1'b0;
  endtask

  // one rising edge with the inputs driven on the previous edge
  task automatic update_model();
    bit sys_prev;
    bit strobe;
    bit hit;
    sys_prev = m_sys;
    // internal reset lifts after the stretch
    if (!rst_n_i) begin
      m_por_cnt = 0;
    end else if (m_por_cnt <= `POR_CYCLES) begin
      m_por_cnt = m_por_cnt + 1;
    end
    m_sys = (m_por_cnt > `POR_CYCLES);
    if (!sys_prev) begin
      load_reset_values();
    end else begin
      // readback sees the old register values
      m_rvalid = rd_en_i;
      if (rd_en_i) begin
        m_rdata = model_readback(addr_i);
      end
      // period change restarts the frame timer
      strobe = 1'b0;
      if (m_fdiv != m_tmr_div) begin
        m_tmr_div   = m_fdiv;
        m_tmr_phase = '0;
      end else begin
        m_tmr_phase = m_tmr_phase + 1;
        if (m_tmr_phase == m_fdiv) begin
          strobe      = 1'b1;
          m_tmr_phase = '0;
        end
      end
      m_txf = strobe;
      if (strobe && los_i && !m_ctrl[1]) begin
        m_count = '0;
      end else if (strobe && m_ctrl[0]) begin
        m_count = m_count + 1;
      end
      // receive activity
      hit = rx_valid_i && (rx_data_i != '0);
      if (hit) begin
        m_hold = m_stretch;
        if (m_rxf != '1) begin
          m_rxf = m_rxf + 1;
        end
      end else if (m_hold != '0) begin
        m_hold = m_hold - 1;
      end
      // heartbeats
      m_fast_cnt = m_fast_cnt + 1;
      if (m_fast_cnt == `HB_FAST_HALF) begin
        m_fast_cnt = 0;
        m_fast     = ~m_fast;
      end
      m_slow_cnt = m_slow_cnt + 1;
      if (m_slow_cnt == `HB_SLOW_HALF) begin
        m_slow_cnt = 0;
        m_slow     = ~m_slow;
      end
      // writes land last
      if (wr_en_i) begin
        case (addr_i)
          `ADDR_CTRL:      m_ctrl = wdata_i[1:0];
          `ADDR_FRAME_DIV: m_fdiv = (wdata_i == '0) ? word_t'(1) : wdata_i;
          `ADDR_STRETCH:   m_stretch = wdata_i;
          default: ;
        endcase
      end
    end
  endtask

  task automatic compare_outputs();
    check_value("tx_frame_o", tx_frame_o, m_txf);
    check_value("tx_data_o", tx_data_o, {m_count, m_count});
    check_value("led_o", led_o, {m_hold != '0, m_slow, m_fast});
    check_value("diag_o", diag_o, {m_hold != '0, m_txf, m_slow, m_fast});
    check_value("rvalid_o", rvalid_o, m_rvalid);
    if (m_rvalid) begin
      check_value("rdata_o", rdata_o, m_rdata);
    end
  endtask

  // ----------------------------------------
  // bus and cycle helpers
  // ----------------------------------------
  // checks outputs mid-cycle and returns after the rising edge
  task automatic tick();
    @(negedge clk_tree_x);
    if (checks_on) begin
      compare_outputs();
    end
    @(posedge clk_tree_x);
    update_model();
  endtask

  task automatic write_reg(input reg_addr_t addr, input word_t data);
    wr_en_i <= 1'b1;
    addr_i  <= addr;
    wdata_i <= data;
    tick();
    wr_en_i <= 1'b0;
  endtask

  // second tick covers the rvalid cycle
  task automatic read_reg(input reg_addr_t addr);
    rd_en_i <= 1'b1;
    addr_i  <= addr;
    tick();
    rd_en_i <= 1'b0;
    tick();
  endtask

  task automatic write_read_same_cycle(input reg_addr_t addr, input word_t data);
    wr_en_i <= 1'b1;
    rd_en_i <= 1'b1;
    addr_i  <= addr;
    wdata_i <= data;
    tick();
    wr_en_i <= 1'b0;
    rd_en_i <= 1'b0;
    tick();
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin
    word_t data;
    seed       = 32'hef6e_e89e;
    m_por_cnt  = 0;
    m_sys      = 1'b0;
    rst_n_i    = 1'b0;
    wr_en_i    = 1'b0;
    rd_en_i    = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    rx_valid_i = 1'b0;
    rx_data_i  = '0;
    los_i      = 1'b0;

    // first edge clears the sequencer and the blocks follow
    tick();
    checks_on = 1'b1;
    repeat (4) tick();
    // external reset released and then the internal stretch
    rst_n_i <= 1'b1;
    repeat (`POR_CYCLES + 4) tick();
    read_reg(`ADDR_ID);
    read_reg(`ADDR_FRAME_DIV);
    read_reg(`ADDR_STRETCH);
    read_reg(`ADDR_CTRL);

    // register path with zero periods
    repeat (40) begin
      data = $random(seed);
      if (rand_below(4) == 0) begin
        data = '0;
      end
      write_reg(reg_addr_t'(rand_below(3)), data);
      read_reg(addr_i);
      read_reg(reg_addr_t'(rand_below(10) + 6));
    end
    write_reg(`ADDR_FRAME_DIV, 32'h0);
    read_reg(`ADDR_FRAME_DIV);
    repeat (5) begin
      write_read_same_cycle(reg_addr_t'(rand_below(3)), $random(seed));
    end

    // counting pattern on short periods
    write_reg(`ADDR_CTRL, 32'h1);
    repeat (10) begin
      write_reg(`ADDR_FRAME_DIV, rand_below(6) + 1);
      repeat (50) tick();
      read_reg(`ADDR_TX_COUNT);
    end

    // los with enable, all off, override only, override and enable
    for (int mode = 0; mode < 4; mode++) begin
      write_reg(`ADDR_CTRL, word_t'(mode ^ (mode >> 1)) ^ 32'h1);
      repeat (3) begin
        write_reg(`ADDR_FRAME_DIV, rand_below(6) + 1);
        repeat (40) begin
          if (rand_below(3) == 0) begin
            los_i <= ~los_i;
          end
          tick();
        end
        read_reg(`ADDR_TX_COUNT);
      end
    end
    los_i <= 1'b0;

    // receive traffic with the led disabled in the first pass
    write_reg(`ADDR_CTRL, 32'h1);
    for (int seg = 0; seg < 6; seg++) begin
      write_reg(`ADDR_STRETCH, (seg == 0) ? 0 : rand_below(8));
      repeat (80) begin
        rx_valid_i <= (rand_below(2) == 1);
        if (rand_below(2) == 0) begin
          rx_data_i <= '0;
        end else begin
          rx_data_i <= {$random(seed), $random(seed)};
        end
        tick();
      end
      rx_valid_i <= 1'b0;
      read_reg(`ADDR_RX_FRAMES);
    end

    repeat (20) tick();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== mcoi_link_top.f ====
+incdir+source
source/mcoi_link_pkg.sv
source/link_cfg_if.sv
source/por_reset_gen.sv
source/heartbeat_blinker.sv
source/frame_pattern_gen.sv
source/rx_activity_monitor.sv
source/link_ctrl_regs.sv
source/mcoi_link_top.sv
dv/tb_mcoi_link_top.sv
